// File: hw/hdg_ctrl_top.sv
`timescale 1ns/1ps

module hdg_ctrl_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cmd_vld,    // Desired heading strobe.
  input  hdg_pkg::hdg_t cmd_hdg,
  input  logic          go,         // Drive enable level.
  input  logic          hdg_vld,    // Gyro sample strobe.
  input  hdg_pkg::hdg_t actual_hdg,
  output hdg_pkg::spd_t lft_spd,
  output hdg_pkg::spd_t rght_spd,
  output logic          lft_dir,
  output logic          rght_dir,
  output logic          lft_pwm,
  output logic          rght_pwm
);

  hdg_err_if i_err_if ();          // Error path, controller to PID.

  //////////////////////////////
  // Heading loop
  //////////////////////////////
  motion_ctrl i_motion_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_hdg    (cmd_hdg),
    .go         (go),
    .hdg_vld    (hdg_vld),
    .actual_hdg (actual_hdg),
    .err        (i_err_if.src)
  );

  pid i_pid (
    .clk      (clk),
    .rst_n    (rst_n),
    .err      (i_err_if.dst),
    .lft_spd  (lft_spd),
    .rght_spd (rght_spd)
  );

  //////////////////////////////
  // Wheel drive
  //////////////////////////////
  mtr_pwm i_lft_pwm (
    .clk   (clk),
    .rst_n (rst_n),
    .spd   (lft_spd),
    .dir   (lft_dir),
    .pwm   (lft_pwm)
  );

  mtr_pwm i_rght_pwm (
    .clk   (clk),
    .rst_n (rst_n),
    .spd   (rght_spd),
    .dir   (rght_dir),
    .pwm   (rght_pwm)
  );

endmodule

// File: hw/hdg_err_if.sv
`timescale 1ns/1ps

// Error path from the motion controller to the PID block.
interface hdg_err_if;

  logic            moving;  // Robot is driving, PID active.
  logic            err_vld; // One-cycle strobe per heading sample.
  hdg_pkg::err_t   error;   // Held between strobes.
  hdg_pkg::frwrd_t frwrd;   // Ramped forward speed.

  // Motion controller side.
  modport src (
    output moving,
    output err_vld,
    output error,
    output frwrd
  );

  // PID side.
  modport dst (
    input moving,
    input err_vld,
    input error,
    input frwrd
  );

endinterface

// File: hw/hdg_pkg.sv
package hdg_pkg;

  //////////////////////////////
  // Loop data types
  //////////////////////////////
  typedef logic [11:0]        hdg_t;   // Absolute heading, wraps at 4096.
  typedef logic signed [11:0] err_t;   // Heading error, actual minus desired.
  typedef logic [9:0]         frwrd_t; // Forward speed, unsigned.
  typedef logic signed [10:0] spd_t;   // Wheel speed, sign gives direction.
  typedef logic [9:0]         duty_t;  // PWM counter and duty magnitude.

  //////////////////////////////
  // Loop constants
  //////////////////////////////
  // Gains are unsigned constants.
  // The PID block zero-extends them before the signed multiply.
  localparam logic [5:0] P_COEFF    = 6'd16;  // Proportional gain.
  localparam logic [4:0] D_COEFF    = 5'd7;   // Derivative gain.

  // Forward ramp.
  localparam frwrd_t     FRWRD_STEP = 10'd24;  // Added per heading sample.
  localparam frwrd_t     FRWRD_MAX  = 10'd768; // Ramp ceiling.

endpackage

// File: hw/motion_ctrl.sv
`timescale 1ns/1ps

module motion_ctrl (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cmd_vld,    // Latch a new desired heading.
  input  hdg_pkg::hdg_t cmd_hdg,
  input  logic          go,         // Level, robot should drive.
  input  logic          hdg_vld,    // New gyro sample strobe.
  input  hdg_pkg::hdg_t actual_hdg,
  hdg_err_if.src        err
);

  hdg_pkg::hdg_t   des_hdg;   // Desired heading.
  logic [10:0]     frwrd_sum; // One spare bit to see the ceiling.
  hdg_pkg::frwrd_t frwrd_nxt;

  //////////////////////////////
  // Desired heading
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      des_hdg <= '0;
    end else if (cmd_vld) begin
      des_hdg <= cmd_hdg;                 // Taken on the strobe edge.
    end
  end

  //////////////////////////////
  // Heading error
  //////////////////////////////
  // Twelve-bit wrap makes the shortest turn fall out of the subtract.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err.error   <= '0;
      err.err_vld <= 1'b0;
    end else begin
      err.err_vld <= hdg_vld;             // Pulse follows the sample by one cycle.
      if (hdg_vld)
        err.error <= hdg_pkg::err_t'(actual_hdg - des_hdg);
    end
  end

  // Moving lags go by one cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      err.moving <= 1'b0;
    else
      err.moving <= go;
  end

  //////////////////////////////
  // Forward ramp
  //////////////////////////////
  assign frwrd_sum = {1'b0, err.frwrd} + {1'b0, hdg_pkg::FRWRD_STEP};

  // Clamp at the ceiling.
  assign frwrd_nxt = (frwrd_sum > {1'b0, hdg_pkg::FRWRD_MAX}) ? hdg_pkg::FRWRD_MAX :
                                                               frwrd_sum[9:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err.frwrd <= '0;
    end else if (!err.moving) begin
      err.frwrd <= '0;                    // Idle, start from standstill.
    end else if (hdg_vld) begin
      err.frwrd <= frwrd_nxt;             // One step per heading sample.
    end
  end

endmodule

// File: hw/mtr_pwm.sv
`timescale 1ns/1ps

module mtr_pwm (
  input  logic          clk,
  input  logic          rst_n,
  input  hdg_pkg::spd_t spd,   // Signed wheel speed.
  output logic          dir,   // High for reverse.
  output logic          pwm
);

  hdg_pkg::duty_t cnt;         // Free-running PWM counter.
  logic [10:0]    mag;         // Magnitude, may reach 1024.
  hdg_pkg::duty_t duty;

  //////////////////////////////
  // Magnitude
  //////////////////////////////
  assign mag = spd[10] ? 11'(-spd) : 11'(spd);

  // Only -1024 lands on bit 10.
  assign duty = mag[10] ? 10'h3FF : mag[9:0];

  //////////////////////////////
  // Counter and compare
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cnt <= '0;
    else
      cnt <= cnt + 10'd1;      // Wraps at 1024.
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm <= 1'b0;
      dir <= 1'b0;
    end else begin
      pwm <= (cnt < duty);     // Zero duty keeps the output low.
      dir <= spd[10];
    end
  end

endmodule

// File: hw/pid.sv
`timescale 1ns/1ps

module pid (
  input  logic          clk,
  input  logic          rst_n,
  hdg_err_if.dst        err,
  output hdg_pkg::spd_t lft_spd,
  output hdg_pkg::spd_t rght_spd
);

  logic               vld_d1, vld_d2;     // Valid strobe, lined up with err_sat.
  logic signed [9:0]  err_sat_nxt;
  logic signed [9:0]  err_sat0, err_sat;  // Saturated error pipeline.
  logic signed [13:0] p_term;
  logic signed [14:0] err_ext;
  logic signed [14:0] sum;
  logic signed [14:0] integrator;
  logic               ov;                 // Integrator would overflow.
  logic signed [8:0]  i_term;
  logic signed [9:0]  stage1, stage2, prev_err; // Last three samples.
  logic signed [10:0] d_diff;
  logic signed [7:0]  d_diff_sat;
  logic signed [12:0] d_term;
  logic signed [13:0] p_ext, i_ext, d_ext;
  logic signed [13:0] pid_term, pid_term_pl;
  logic signed [10:0] frwrd_ext;
  logic signed [10:0] raw_lft, raw_rght;

  //////////////////////////////
  // Error pipeline
  //////////////////////////////
  // Clip to 10 bits when bits 11..9 disagree.
  assign err_sat_nxt = (!err.error[11] && |err.error[10:9])   ? 10'sh1FF :
                       (err.error[11] && !(&err.error[10:9])) ? 10'sh200 :
                       err.error[9:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_sat0 <= '0;
      err_sat  <= '0;
      vld_d1   <= 1'b0;
      vld_d2   <= 1'b0;
    end else begin
      err_sat0 <= err_sat_nxt;
      err_sat  <= err_sat0;
      vld_d1   <= err.err_vld;
      vld_d2   <= vld_d1;             // Now aligned with err_sat.
    end
  end

  //////////////////////////////
  // P term
  //////////////////////////////
  assign p_term = err_sat * $signed({1'b0, hdg_pkg::P_COEFF});

  //////////////////////////////
  // I term
  //////////////////////////////
  assign err_ext = {{5{err_sat[9]}}, err_sat};
  assign sum     = err_ext + integrator;

  // Same operand signs but a flipped result sign.
  assign ov = (err_ext[14] == integrator[14]) && (sum[14] != err_ext[14]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integrator <= '0;
    end else if (!err.moving) begin
      integrator <= '0;               // Idle robot forgets its history.
    end else if (vld_d2 && !ov) begin
      integrator <= sum;
    end
  end

  assign i_term = integrator[14:6];   // Top nine bits.

  //////////////////////////////
  // D term
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage1   <= '0;
      stage2   <= '0;
      prev_err <= '0;
    end else if (vld_d2) begin
      stage1   <= err_sat;            // Shift once per sample.
      stage2   <= stage1;
      prev_err <= stage2;
    end
  end

  // Eleven bits so the difference itself cannot wrap.
  assign d_diff = {err_sat[9], err_sat} - {prev_err[9], prev_err};

  assign d_diff_sat = (!d_diff[10] && |d_diff[9:7])   ? 8'sh7F :
                      (d_diff[10] && !(&d_diff[9:7])) ? 8'sh80 :
                      d_diff[7:0];

  assign d_term = d_diff_sat * $signed({1'b0, hdg_pkg::D_COEFF});

  //////////////////////////////
  // Sum and wheel mix
  //////////////////////////////
  assign p_ext = {p_term[13], p_term[13:1]};  // Half of P.
  assign i_ext = {{5{i_term[8]}}, i_term};
  assign d_ext = {d_term[12], d_term};

  assign pid_term = p_ext + i_ext + d_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pid_term_pl <= '0;
    else
      pid_term_pl <= pid_term;
  end

  assign frwrd_ext = $signed({1'b0, err.frwrd});

  // Positive PID steers right, so the left wheel speeds up.
  assign raw_lft  = err.moving ? frwrd_ext + $signed(pid_term_pl[13:3]) : 11'sh000;
  assign raw_rght = err.moving ? frwrd_ext - $signed(pid_term_pl[13:3]) : 11'sh000;

  // A negative result against the PID sign means the add wrapped.
  assign lft_spd  = (!pid_term_pl[13] && raw_lft[10])  ? 11'sh3FF : raw_lft;
  assign rght_spd = (pid_term_pl[13] && raw_rght[10])  ? 11'sh3FF : raw_rght;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the heading loop testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module hdg_ctrl_tb -o hdg_ctrl_sim

# The simulator exits nonzero on a failed check, so the log decides.
./obj_dir/hdg_ctrl_sim > sim.log 2>&1 || true
cat sim.log

grep -q ">>> PASS" sim.log

// File: sim/hdg_ctrl_assertions.sv
`timescale 1ns/1ps

module hdg_ctrl_assertions (
  input logic          clk,
  input logic          rst_n,
  input logic          moving,
  input logic          err_vld,
  input hdg_pkg::err_t error,     // Error word from the motion controller.
  input hdg_pkg::spd_t spd_a,
  input hdg_pkg::spd_t spd_b,
  input logic          pwm
);

  // Idle robot keeps both wheels still.
  idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !moving |-> (spd_a == 0 && spd_b == 0))
    else $error("wheel speed nonzero while idle");

  // Zero speed gives no pulse on the next edge.
  pwm_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (spd_a == 0) |=> !pwm)
    else $error("pwm high for a stopped wheel");

  // Error is held between strobes and only moves with a sample.
  err_held: assert property (@(posedge clk) disable iff (!rst_n)
    (error != $past(error)) |-> err_vld)
    else $error("error changed without a sample strobe");

endmodule

bind pid hdg_ctrl_assertions i_pid_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .moving  (err.moving),
  .err_vld (err.err_vld),
  .error   (err.error),
  .spd_a   (lft_spd),
  .spd_b   (rght_spd),
  .pwm     (1'b0)
);

bind mtr_pwm hdg_ctrl_assertions i_pwm_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .moving  (1'b1),
  .err_vld (1'b0),
  .error   ('0),
  .spd_a   (spd),
  .spd_b   (spd),
  .pwm     (pwm)
);

// File: sim/hdg_ctrl_tb.sv
`timescale 1ns/1ps

module hdg_ctrl_tb;

  logic          clk;
  logic          rst_n;
  logic          cmd_vld;
  hdg_pkg::hdg_t cmd_hdg;
  logic          go;
  logic          hdg_vld;
  hdg_pkg::hdg_t actual_hdg;
  hdg_pkg::spd_t lft_spd;
  hdg_pkg::spd_t rght_spd;
  logic          lft_dir, rght_dir;
  logic          lft_pwm, rght_pwm;

  // Loop model with one variable per register of the design.
  int m_des, m_err, m_frwrd, m_sat0, m_sat1, m_integ;
  int m_st1, m_st2, m_prev, m_pid, m_cnt;
  bit m_vld, m_moving, m_vld1, m_vld2;
  bit m_pwm_l, m_pwm_r, m_dir_l, m_dir_r;
  int drift0, drift1, guard;

  hdg_ctrl_top i_hdg_ctrl_top (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;                     // 10 ns period.

  //////////////////////////////
  // Model helpers
  //////////////////////////////
  function automatic int clamp(int v, int lo, int hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  // Idle wheels stop; a sum past the top end pins at full speed.
  function automatic int wheel(int frwrd, int pid_hi, bit moving);
    if (!moving) return 0;
    return clamp(frwrd + pid_hi, -1024, 1023);
  endfunction

  function automatic int duty(int spd);
    return clamp((spd < 0) ? -spd : spd, 0, 1023); // Saturated magnitude.
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(string name, int got, int exp);
    assert (got == exp) else
      abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Advance the model across one rising edge with the last pipeline stage first.
  task automatic model_step();
    int l, r, s, e;
    l = wheel(m_frwrd, m_pid >>> 3, m_moving);
    r = wheel(m_frwrd, -(m_pid >>> 3), m_moving);
    m_pwm_l = m_cnt < duty(l);
    m_pwm_r = m_cnt < duty(r);
    m_dir_l = l < 0;
    m_dir_r = r < 0;
    m_cnt   = (m_cnt + 1) % 1024;          // Free-running counter.
    // Half P, top nine integrator bits, saturated D.
    m_pid = ((m_sat1 * int'(hdg_pkg::P_COEFF)) >>> 1) + (m_integ >>> 6) +
            clamp(m_sat1 - m_prev, -128, 127) * int'(hdg_pkg::D_COEFF);
    s = m_sat1 + m_integ;
    if (!m_moving)
      m_integ = 0;
    else if (m_vld2 && s >= -16384 && s <= 16383)
      m_integ = s;                          // Overflow leaves it alone.
    if (m_vld2) begin
      m_prev = m_st2;
      m_st2  = m_st1;
      m_st1  = m_sat1;
    end
    m_vld2 = m_vld1;
    m_vld1 = m_vld;
    m_sat1 = m_sat0;
    m_sat0 = clamp(m_err, -512, 511);
    // Motion controller.
    if (!m_moving)
      m_frwrd = 0;
    else if (hdg_vld)
      m_frwrd = clamp(m_frwrd + int'(hdg_pkg::FRWRD_STEP), 0, int'(hdg_pkg::FRWRD_MAX));
    if (hdg_vld) begin
      e = (int'(actual_hdg) - m_des + 4096) % 4096;
      m_err = (e >= 2048) ? e - 4096 : e;  // Read as signed.
    end
    m_vld    = hdg_vld;
    m_moving = go;
    if (cmd_vld)
      m_des = int'(cmd_hdg);
  endtask

  // Check outputs on the falling edge and then drive the next inputs.
  task automatic run_cycle(bit cv, int ch, bit g, bit hv, int ah);
    int l, r;
    @(negedge clk);
    l = wheel(m_frwrd, m_pid >>> 3, m_moving);
    r = wheel(m_frwrd, -(m_pid >>> 3), m_moving);
    check_value("lft_spd", int'(lft_spd), l);
    check_value("rght_spd", int'(rght_spd), r);
    check_value("lft_dir", int'(lft_dir), int'(m_dir_l));
    check_value("rght_dir", int'(rght_dir), int'(m_dir_r));
    check_value("lft_pwm", int'(lft_pwm), int'(m_pwm_l));
    check_value("rght_pwm", int'(rght_pwm), int'(m_pwm_r));
    cmd_vld    = cv;
    cmd_hdg    = hdg_pkg::hdg_t'(ch);
    go         = g;
    hdg_vld    = hv;
    actual_hdg = hdg_pkg::hdg_t'(ah);
    model_step();
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    void'($urandom(77502));
    rst_n      = 1'b0;
    cmd_vld    = 1'b0;
    cmd_hdg    = '0;
    go         = 1'b0;
    hdg_vld    = 1'b0;
    actual_hdg = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    model_step();                           // Edge right after release.
    // Idle with random headings but go low.
    for (int i = 0; i < 30; i++)
      run_cycle($urandom_range(3) == 0, $urandom_range(4095), 1'b0,
                $urandom_range(3) == 0, $urandom_range(4095));
    // Sparse random samples with large errors both ways.
    for (int i = 0; i < 800; i++)
      run_cycle($urandom_range(7) == 0, $urandom_range(4095), $urandom_range(15) != 0,
                $urandom_range(3) == 0, $urandom_range(4095));
    // Flush to zero error and ramp to the ceiling.
    run_cycle(1'b1, 1234, 1'b0, 1'b0, 1234);
    repeat (10) run_cycle(1'b0, 0, 1'b0, 1'b1, 1234);
    guard = 0;
    while (int'(lft_spd) != int'(hdg_pkg::FRWRD_MAX) ||
           int'(rght_spd) != int'(hdg_pkg::FRWRD_MAX)) begin
      run_cycle(1'b0, 0, 1'b1, guard[0], 1234);
      guard++;
      assert (guard < 500) else abort_run("Forward ramp never reached its ceiling");
    end
    repeat (20) run_cycle(1'b0, 0, 1'b1, 1'b1, 1234);
    repeat (5) run_cycle(1'b0, 0, 1'b0, 1'b0, 1234); // go falls.
    // Constant error drives the integrator into overflow.
    run_cycle(1'b1, 0, 1'b1, 1'b0, 0);
    for (int i = 0; i < 400; i++) begin
      run_cycle(1'b0, 0, 1'b1, 1'b1, 200);
      if (i == 20) drift0 = int'(lft_spd) - int'(rght_spd);
      if (i == 60) drift1 = int'(lft_spd) - int'(rght_spd);
    end
    assert (drift1 > drift0) else abort_run("Wheel speeds did not drift apart");
    repeat (300) run_cycle(1'b0, 0, 1'b1, 1'b1, 4096 - 200);
    // Back-to-back samples with random headings.
    for (int i = 0; i < 600; i++)
      run_cycle($urandom_range(15) == 0, $urandom_range(4095), 1'b1,
                1'b1, $urandom_range(4095));
    repeat (5) run_cycle(1'b0, 0, 1'b0, 1'b0, 0);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: vlog.f
hw/hdg_pkg.sv
hw/hdg_err_if.sv
hw/motion_ctrl.sv
hw/pid.sv
hw/mtr_pwm.sv
hw/hdg_ctrl_top.sv
sim/hdg_ctrl_assertions.sv
sim/hdg_ctrl_tb.sv
